/* filelist.f */
+incdir+src
src/radio_ctrl_pkg.sv
src/settings_intake.sv
src/misc_ctrl_regs.sv
src/vita_timekeeper.sv
src/status_readback.sv
src/radio_ctrl_core.sv
testbench/ctrl_checker.sv
testbench/tb_radio_ctrl_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the radio control testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f filelist.f \
   --top-module tb_radio_ctrl_core -o sim_radio_ctrl
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_radio_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Errors found" "$LOG"; then
   exit 1
fi
exit 0

/* src/misc_ctrl_regs.sv */
//////////////////////////////////////////////////
// Miscellaneous setting registers for the clock,
// SERDES, ADC and PHY pins, plus the LED source mux.
// Fed from the registered settings record
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module misc_ctrl_regs
   import radio_ctrl_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  set_bus_t   set_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   input  logic       good_sync_i,
   input  logic       run_rx_i,
   input  logic       run_tx_i,
   output ctrl_pins_t ctrl_o,
   output logic [7:0] leds_o
);

   localparam logic [`SET_ADDR_W-1:0] ADDR_CLK     = `SR_MISC + 8'd0;
   localparam logic [`SET_ADDR_W-1:0] ADDR_SERDES  = `SR_MISC + 8'd1;
   localparam logic [`SET_ADDR_W-1:0] ADDR_ADC     = `SR_MISC + 8'd2;
   localparam logic [`SET_ADDR_W-1:0] ADDR_LED_SW  = `SR_MISC + 8'd3;
   localparam logic [`SET_ADDR_W-1:0] ADDR_PHY     = `SR_MISC + 8'd4;
   localparam logic [`SET_ADDR_W-1:0] ADDR_LED_SRC = `SR_MISC + 8'd6;

   logic [4:0] clock_outs;
   logic [3:0] serdes_outs;
   logic [3:0] adc_outs;
   logic       phy_reset;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   //////////////////////////////////////////////////
   // Register decode
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_outs  <= '0;
         serdes_outs <= '0;
         adc_outs    <= '0;
         phy_reset   <= 1'b0;
         led_sw      <= '0;
         led_src     <= `LED_SRC_RESET;
      end else if (set_i.stb) begin
         // Each register keeps only the low data bits
         case (set_i.addr)
            ADDR_CLK:     clock_outs  <= set_i.data[4:0];
            ADDR_SERDES:  serdes_outs <= set_i.data[3:0];
            ADDR_ADC:     adc_outs    <= set_i.data[3:0];
            ADDR_LED_SW:  led_sw      <= set_i.data[7:0];
            ADDR_PHY:     phy_reset   <= set_i.data[0];
            ADDR_LED_SRC: led_src     <= set_i.data[7:0];
            default:      ;
         endcase
      end
   end

   // Pin fields in the same bit order as the data word
   assign {ctrl_o.clock_ready, ctrl_o.clk_en, ctrl_o.clk_sel} = clock_outs;
   assign {ctrl_o.ser_enable, ctrl_o.ser_prbsen,
           ctrl_o.ser_loopen, ctrl_o.ser_rx_en} = serdes_outs;
   assign {ctrl_o.adc_oe_a, ctrl_o.adc_on_a,
           ctrl_o.adc_oe_b, ctrl_o.adc_on_b} = adc_outs;
   assign ctrl_o.phy_resetn = ~phy_reset;

   //////////////////////////////////////////////////
   // LEDs, source bit 1 selects hardware status
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

/* src/radio_ctrl_consts.svh */
//////////////////////////////////////////////////
// Settings addresses, readback indices and widths
// for the radio control core. Include wherever a
// macro is needed; the guard makes repeats harmless
//////////////////////////////////////////////////
`ifndef RADIO_CTRL_CONSTS_SVH
`define RADIO_CTRL_CONSTS_SVH

// Settings bus widths
`define SET_ADDR_W 8
`define SET_DATA_W 32

// Setting register bases, offsets are added locally
`define SR_MISC   8'd0
`define SR_TIME64 8'd10

// Readback index width and word indices
`define RB_ADDR_W  4
`define RB_SIMMODE 4'd9
`define RB_TIME_HI 4'd10
`define RB_TIME_LO 4'd11
`define RB_COMPAT  4'd12
`define RB_PPS_HI  4'd14
`define RB_PPS_LO  4'd15

// Bump when the register map changes, major in the high half
`define COMPAT_NUM {16'd7, 16'd0}

// LEDs 1 to 4 follow hardware status out of reset
`define LED_SRC_RESET 8'b0001_1110

`endif

/* src/radio_ctrl_core.sv */
//////////////////////////////////////////////////
// Radio slow-control and timekeeping core. Settings
// intake feeds the register bank and timekeeper,
// readback returns status and time words
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module radio_ctrl_core
   import radio_ctrl_pkg::*;
(
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  set_bus_t              set_i,
   input  logic                  pps_i,
   input  logic [`RB_ADDR_W-1:0] rb_addr_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_up_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   output ctrl_pins_t            ctrl_o,
   output logic [7:0]            leds_o,
   output logic [31:0]           rb_data_o,
   output logic                  pps_int_o,
   output logic                  good_sync_o
);

   set_bus_t   set_q;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       good_sync;

   settings_intake u_intake (
      .dsp_clk (dsp_clk),
      .por_rst (por_rst),
      .set_i   (set_i),
      .set_o   (set_q)
   );

   misc_ctrl_regs u_misc (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .set_i            (set_q),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .good_sync_i      (good_sync),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .ctrl_o           (ctrl_o),
      .leds_o           (leds_o)
   );

   vita_timekeeper u_time (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_i           (set_q),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int_o),
      .good_sync_o     (good_sync)
   );

   status_readback u_readback (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .rb_addr_i       (rb_addr_i),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .rb_data_o       (rb_data_o)
   );

   assign good_sync_o = good_sync;

endmodule

/* src/radio_ctrl_pkg.sv */
//////////////////////////////////////////////////
// Types shared by the radio control RTL and its
// checker. Modules pull them in by wildcard import
//////////////////////////////////////////////////
`include "radio_ctrl_consts.svh"

package radio_ctrl_pkg;

   // One settings write, strobe qualifies the cycle
   typedef struct packed {
      logic                   stb;
      logic [`SET_ADDR_W-1:0] addr;
      logic [`SET_DATA_W-1:0] data;
   } set_bus_t;

   // Board control pins
   typedef struct packed {
      // Clock generator
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      // SERDES
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      // ADC channels A and B
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      // Ethernet PHY, active low
      logic       phy_resetn;
   } ctrl_pins_t;

   // 64-bit VITA time, seconds side in hi
   typedef struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
   } vita_time_t;

endpackage

/* src/settings_intake.sv */
//////////////////////////////////////////////////
// Input stage of the settings path. Registers each
// write so all decoders see one aligned record
//////////////////////////////////////////////////
`timescale 1ns/10ps

module settings_intake
   import radio_ctrl_pkg::*;
(
   input  logic     dsp_clk,
   input  logic     por_rst,
   input  set_bus_t set_i,
   output set_bus_t set_o
);

   set_bus_t set_q;

   // Payload rides along with the strobe
   always_ff @(posedge dsp_clk) begin
      set_q.addr <= set_i.addr;
      set_q.data <= set_i.data;
   end

   // Strobe is the only control bit here
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_q.stb <= 1'b0;
      end else begin
         set_q.stb <= set_i.stb;
      end
   end

   assign set_o = set_q;

endmodule

/* src/status_readback.sv */
//////////////////////////////////////////////////
// Registered readback mux. The word for rb_addr_i
// shows on rb_data_o one cycle later
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module status_readback
   import radio_ctrl_pkg::*;
(
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  logic [`RB_ADDR_W-1:0] rb_addr_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   input  vita_time_t            vita_time_i,
   input  vita_time_t            vita_time_pps_i,
   output logic [31:0]           rb_data_o
);

   logic [31:0] rb_word;
   logic [31:0] rb_q;

   // Word select, unlisted indices read zero
   always_comb begin
      case (rb_addr_i)
         `RB_SIMMODE: rb_word = {sim_mode_i, 27'd0, clock_divider_i};
         `RB_TIME_HI: rb_word = vita_time_i.hi;
         `RB_TIME_LO: rb_word = vita_time_i.lo;
         `RB_COMPAT:  rb_word = `COMPAT_NUM;
         `RB_PPS_HI:  rb_word = vita_time_pps_i.hi;
         `RB_PPS_LO:  rb_word = vita_time_pps_i.lo;
         default:     rb_word = 32'd0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_q <= 32'd0;
      end else begin
         rb_q <= rb_word;
      end
   end

   assign rb_data_o = rb_q;

endmodule

/* src/vita_timekeeper.sv */
//////////////////////////////////////////////////
// Free-running 64-bit VITA time with software load.
// PPS is synchronised and its rising edge latches
// the time and raises the sticky sync flag
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module vita_timekeeper
   import radio_ctrl_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  set_bus_t   set_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o,
   output logic       good_sync_o
);

   localparam logic [`SET_ADDR_W-1:0] ADDR_TIME_HI = `SR_TIME64 + 8'd0;
   localparam logic [`SET_ADDR_W-1:0] ADDR_TIME_LO = `SR_TIME64 + 8'd1;

   logic [63:0] time_cnt;
   logic [63:0] time_pps;
   logic [31:0] pending_hi;
   logic        load_lo;
   logic        pps_meta;
   logic        pps_sync;
   logic        pps_dly;
   logic        pps_edge;
   logic        pps_int_q;
   logic        good_sync_q;

   assign load_lo = set_i.stb && (set_i.addr == ADDR_TIME_LO);

   // High word waits here until the low word arrives
   always_ff @(posedge dsp_clk) begin
      if (set_i.stb && (set_i.addr == ADDR_TIME_HI)) begin
         pending_hi <= set_i.data;
      end
   end

   //////////////////////////////////////////////////
   // Time counter
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_cnt <= '0;
      end else if (load_lo) begin
         time_cnt <= {pending_hi, set_i.data};
      end else begin
         time_cnt <= time_cnt + 64'd1;
      end
   end

   //////////////////////////////////////////////////
   // PPS sync, edge detect and capture
   assign pps_edge = pps_sync & ~pps_dly;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta    <= 1'b0;
         pps_sync    <= 1'b0;
         pps_dly     <= 1'b0;
         pps_int_q   <= 1'b0;
         good_sync_q <= 1'b0;
         time_pps    <= '0;
      end else begin
         pps_meta    <= pps_i;
         pps_sync    <= pps_meta;
         pps_dly     <= pps_sync;
         pps_int_q   <= pps_edge;
         // Stays set until the next reset
         good_sync_q <= good_sync_q | pps_edge;
         if (pps_edge) begin
            time_pps <= time_cnt;
         end
      end
   end

   assign vita_time_o     = time_cnt;
   assign vita_time_pps_o = time_pps;
   assign pps_int_o       = pps_int_q;
   assign good_sync_o     = good_sync_q;

endmodule

/* testbench/ctrl_checker.sv */
//////////////////////////////////////////////////
// Watches the radio control core ports, keeps its
// own model of the time counter and compares each
// test's result. Tasks are called by the testbench
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module ctrl_checker
   import radio_ctrl_pkg::*;
(
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  set_bus_t              set_i,
   input  logic                  pps_i,
   input  logic [`RB_ADDR_W-1:0] rb_addr_i,
   input  ctrl_pins_t            ctrl_i,
   input  logic [7:0]            leds_i,
   input  logic [31:0]           rb_data_i,
   input  logic                  pps_int_i,
   input  logic                  good_sync_i,
   output int                    errors_o
);

   int          edge_cnt = 0;
   int          load_edge = 0;
   int          pulse_cnt = 0;
   int          test_cnt = 0;
   int          error_cnt = 0;
   logic [31:0] pending_hi = '0;
   logic [63:0] load_val = '0;
   logic [63:0] pps_time = '0;
   logic        pps_prev = 1'b0;

   assign errors_o = error_cnt;

   always @(posedge dsp_clk) begin
      edge_cnt <= edge_cnt + 1;
   end

   // Counter value held just after edge k
   function automatic logic [63:0] time_after(input int k);
      return load_val + 64'(k - load_edge);
   endfunction

   //////////////////////////////////////////////////
   // Port monitor, sampled away from the rising edge
   always @(negedge dsp_clk) begin
      if (!por_rst) begin
         if (set_i.stb && (set_i.addr == `SR_TIME64)) begin
            pending_hi <= set_i.data;
         end
         // Intake stage, then the counter loads one edge later
         if (set_i.stb && (set_i.addr == `SR_TIME64 + 8'd1)) begin
            load_val  <= {pending_hi, set_i.data};
            load_edge <= edge_cnt + 2;
         end
         // Two sync flops, captured value is the one after edge +2
         if (pps_i && !pps_prev) begin
            pps_time <= time_after(edge_cnt + 2);
         end
         if (pps_int_i) begin
            pulse_cnt <= pulse_cnt + 1;
         end
      end
      pps_prev <= pps_i;
   end

   task automatic compare(input string sig, input logic [31:0] exp_v,
                          input logic [31:0] act_v, inout bit ok);
      if (exp_v !== act_v) begin
         $display("mismatch at %0d ns: %s expected %0h actual %0h",
                  $time, sig, exp_v, act_v);
         ok = 1'b0;
      end
   endtask

   task automatic close_test(input string name, input bit ok);
      test_cnt = test_cnt + 1;
      if (!ok) begin
         error_cnt = error_cnt + 1;
      end
      $display("%s %s", ok ? "PASS" : "FAIL", name);
   endtask

   task automatic note_failure(input string msg);
      $display("%s", msg);
      error_cnt = error_cnt + 1;
   endtask

   task automatic check_reset(input string name);
      bit ok;
      ok = 1'b1;
      // Only phy_resetn is high, it sits in bit 0
      compare("ctrl_o", 32'h0000_0001, {18'd0, ctrl_i}, ok);
      compare("leds_o", 32'd0, {24'd0, leds_i}, ok);
      compare("rb_data_o", 32'd0, rb_data_i, ok);
      compare("pps_int_o", 32'd0, {31'd0, pps_int_i}, ok);
      compare("good_sync_o", 32'd0, {31'd0, good_sync_i}, ok);
      close_test(name, ok);
   endtask

   task automatic check_ctrl(input logic [13:0] exp_v, input string name);
      bit ok;
      ok = 1'b1;
      compare("ctrl_o", {18'd0, exp_v}, {18'd0, ctrl_i}, ok);
      close_test(name, ok);
   endtask

   task automatic check_leds(input logic [7:0] exp_v, input string name);
      bit ok;
      ok = 1'b1;
      compare("leds_o", {24'd0, exp_v}, {24'd0, leds_i}, ok);
      close_test(name, ok);
   endtask

   // Mode 0 takes the trace value, 1 the time model, 2 the PPS capture
   task automatic check_read(input logic [31:0] exp_v, input logic [1:0] mode,
                             input string name);
      logic [63:0] full;
      logic [31:0] want;
      bit          hi_half;
      bit          ok;
      ok = 1'b1;
      hi_half = (rb_addr_i == `RB_TIME_HI) || (rb_addr_i == `RB_PPS_HI);
      want = exp_v;
      if (mode != 2'd0) begin
         // Word was registered from the value before the last edge
         full = (mode == 2'd1) ? time_after(edge_cnt - 1) : pps_time;
         want = hi_half ? full[63:32] : full[31:0];
      end
      compare("rb_data_o", want, rb_data_i, ok);
      close_test(name, ok);
   endtask

   task automatic check_pps(input logic [31:0] exp_v, input string name);
      bit ok;
      ok = 1'b1;
      compare("pps_int_o pulses", exp_v, 32'(pulse_cnt), ok);
      compare("good_sync_o", 32'd1, {31'd0, good_sync_i}, ok);
      close_test(name, ok);
   endtask

   task automatic print_summary();
      $display("%0d tests run, %0d errors", test_cnt, error_cnt);
   endtask

endmodule

/* testbench/ctrl_trace.txt */
# op cycles a b expect name, a/b/expect in hex; write: a=addr b=data expect=ctrl_o
# status: a={sim,clk,link,rx,tx} b=divider expect=leds_o; read: a=index b=0 trace/1 time/2 pps
write  3 20 ffffffff 0001     unused_addr_write
read   1 0c 0        00070000 compat_read
write  3 00 0000001b 3601     clock_outputs
write  3 01 0000000a 3741     serdes_outputs
write  3 02 00000005 374b     adc_outputs
write  3 04 00000001 374a     phy_reset
write  3 05 ffffffff 374a     unused_offset_write
write  3 03 000000a5 374a     led_software_value
status 2 0d 3        b5       leds_reset_mask
write  3 06 00000000 374a     led_source_clear
status 2 0d 3        a5       leds_software_only
write  3 06 0000001e 374a     led_source_restore
status 2 1d 9        b5       status_sim_mode
read   1 09 0        80000009 simmode_read
read   1 05 0        00000000 unlisted_read
write  3 0a 00000007 374a     time_hi_write
write  3 0b fffffff6 374a     time_lo_load
wait   5 0  0        0        time_settle
read   1 0a 1        0        time_hi_read
read   1 0b 1        0        time_lo_read
pps    4 0  0        1        pps_single_pulse
status 2 0d 3        b7       leds_after_sync
read   1 0e 2        0        pps_hi_read
read   1 0f 2        0        pps_lo_read
read   1 0b 1        0        time_lo_later

/* testbench/tb_radio_ctrl_core.sv */
//////////////////////////////////////////////////
// Testbench for the radio control core. Replays the
// trace file on the DUT while ctrl_checker compares
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "radio_ctrl_consts.svh"

module tb_radio_ctrl_core
   import radio_ctrl_pkg::*;
();

   logic                  dsp_clk = 1'b0;
   logic                  por_rst;
   set_bus_t              set_in;
   logic                  pps_in;
   logic [`RB_ADDR_W-1:0] rb_addr;
   logic                  sim_mode;
   logic [3:0]            clock_divider;
   logic                  clk_status;
   logic                  serdes_link_up;
   logic                  run_rx;
   logic                  run_tx;
   ctrl_pins_t            ctrl;
   logic [7:0]            leds;
   logic [31:0]           rb_data;
   logic                  pps_int;
   logic                  good_sync;
   int                    errors;
   int                    trace_len = 0;

   // Trace records with one entry per data line
   string       op_q[$];
   int          cyc_q[$];
   logic [31:0] a_q[$];
   logic [31:0] b_q[$];
   logic [31:0] exp_q[$];
   string       name_q[$];

   always #5 dsp_clk = ~dsp_clk;

   radio_ctrl_core u_dut (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .set_i            (set_in),
      .pps_i            (pps_in),
      .rb_addr_i        (rb_addr),
      .sim_mode_i       (sim_mode),
      .clock_divider_i  (clock_divider),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (serdes_link_up),
      .run_rx_i         (run_rx),
      .run_tx_i         (run_tx),
      .ctrl_o           (ctrl),
      .leds_o           (leds),
      .rb_data_o        (rb_data),
      .pps_int_o        (pps_int),
      .good_sync_o      (good_sync)
   );

   ctrl_checker u_chk (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_i       (set_in),
      .pps_i       (pps_in),
      .rb_addr_i   (rb_addr),
      .ctrl_i      (ctrl),
      .leds_i      (leds),
      .rb_data_i   (rb_data),
      .pps_int_i   (pps_int),
      .good_sync_i (good_sync),
      .errors_o    (errors)
   );

   // Inputs change 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge dsp_clk);
      #1;
   endtask

   task automatic load_trace(output bit ok);
      int          fd;
      int          n;
      string       line;
      string       op;
      string       name;
      int          cyc;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] e;
      ok = 1'b0;
      fd = $fopen("testbench/ctrl_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open the trace file testbench/ctrl_trace.txt");
      end else begin
         // Comment and blank lines do not give six fields
         while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %d %h %h %h %s", op, cyc, a, b, e, name);
            if (n == 6) begin
               op_q.push_back(op);
               cyc_q.push_back(cyc);
               a_q.push_back(a);
               b_q.push_back(b);
               exp_q.push_back(e);
               name_q.push_back(name);
            end
         end
         $fclose(fd);
         ok = (op_q.size() > 0);
         if (!ok) begin
            $display("the trace file holds no records");
         end
      end
   endtask

   task automatic run_record(input int i);
      int guard;
      guard = 0;
      if (op_q[i] == "write") begin
         set_in.stb  = 1'b1;
         set_in.addr = a_q[i][7:0];
         set_in.data = b_q[i];
         next_cycle();
         set_in.stb = 1'b0;
         // Register edge follows the intake edge
         next_cycle();
         u_chk.check_ctrl(exp_q[i][13:0], name_q[i]);
         repeat (cyc_q[i] - 2) next_cycle();
      end else if (op_q[i] == "status") begin
         {sim_mode, clk_status, serdes_link_up, run_rx, run_tx} = a_q[i][4:0];
         clock_divider = b_q[i][3:0];
         repeat (cyc_q[i]) next_cycle();
         u_chk.check_leds(exp_q[i][7:0], name_q[i]);
      end else if (op_q[i] == "read") begin
         rb_addr = a_q[i][3:0];
         next_cycle();
         u_chk.check_read(exp_q[i], b_q[i][1:0], name_q[i]);
         repeat (cyc_q[i] - 1) next_cycle();
      end else if (op_q[i] == "pps") begin
         pps_in = 1'b1;
         repeat (cyc_q[i]) next_cycle();
         pps_in = 1'b0;
         while (!good_sync && guard < 8) begin
            next_cycle();
            guard = guard + 1;
         end
         // Let the interrupt pulse finish before counting
         repeat (2) next_cycle();
         u_chk.check_pps(exp_q[i], name_q[i]);
      end else if (op_q[i] == "wait") begin
         repeat (cyc_q[i]) next_cycle();
      end else begin
         u_chk.note_failure({"unknown trace operation ", op_q[i]});
      end
   endtask

   initial begin
      bit ok;
      por_rst        = 1'b1;
      set_in         = '0;
      pps_in         = 1'b0;
      rb_addr        = '0;
      sim_mode       = 1'b0;
      clock_divider  = 4'd0;
      clk_status     = 1'b0;
      serdes_link_up = 1'b0;
      run_rx         = 1'b0;
      run_tx         = 1'b0;
      load_trace(ok);
      if (!ok) begin
         $display("Errors found");
         $finish;
      end else begin
         trace_len = op_q.size();
         repeat (16) @(posedge dsp_clk);
         #1;
         por_rst = 1'b0;
         next_cycle();
         u_chk.check_reset("reset_values");
         foreach (op_q[i]) begin
            run_record(i);
         end
         u_chk.print_summary();
         if (errors == 0) begin
            $display("No errors");
         end else begin
            $display("Errors found");
         end
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Watchdog allows 20 cycles per record plus margin
   initial begin
      wait (trace_len > 0);
      repeat (trace_len * 20 + 200) @(posedge dsp_clk);
      $display("timeout: the trace did not finish within %0d cycles",
               trace_len * 20 + 200);
      $display("Errors found");
      $finish;
   end

endmodule
